// ==== src.f ====
+incdir+hdl
hdl/tensor_pkg.sv
hdl/tensor_ctrl_pkg.sv
hdl/scalar_multiplier.sv
hdl/tensor_buffer.sv
hdl/tensor_product.sv
hdl/tensor_product_top.sv
test/tensor_product_tb.sv

// ==== Makefile ====
# Verilator build and run of the tensor contraction testbench

VERILATOR ?= verilator
TOP       ?= tensor_product_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TB PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tensor_product_tb.sv ====
//////////////////////////////////////////////////
// Testbench with LFSR stimulus, contraction model,
// output monitor and watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tensor_product_tb;

  localparam logic [31:0] SEED      = 32'd1986;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam int NUM_TESTS   = 16;
  // Worst case compute and load per job
  localparam int JOB_CYCLES  = 4 * 4 * 4 * 4 * 20;
  localparam int LOAD_CYCLES = 2 * 64 * 4;
  localparam int BUDGET      = NUM_TESTS * (JOB_CYCLES + LOAD_CYCLES) + 10;

  // 2x2x2 with A and B both 1..8 in row-major order
  localparam logic [15:0] FIXED_OUT [8] = '{16'd7, 16'd10, 16'd15, 16'd22,
                                            16'd67, 16'd78, 16'd91, 16'd106};

  logic        CLK;
  logic        RST;
  logic        start;
  logic [2:0]  size_a_i, size_a_j, size_a_k;
  logic [2:0]  size_b_i, size_b_j, size_b_k;
  logic        a_in_i_enable, a_in_j_enable, a_in_k_enable;
  logic        b_in_i_enable, b_in_j_enable, b_in_k_enable;
  logic [15:0] data_a_in;
  logic [15:0] data_b_in;
  logic        ready;
  logic        error;
  logic        out_i_enable, out_j_enable, out_k_enable;
  logic [15:0] data_out;

  logic [31:0] lfsr;
  // Operands and expected result, address i*16 + j*4 + k
  logic [15:0] op_a [64];
  logic [15:0] op_b [64];
  logic [15:0] exp_out [64];
  int          sz_ai, sz_aj, sz_ak, sz_bi, sz_bj, sz_bk;
  int          errors;
  int          checks;
  int          test_errors;
  int          test_num;

  // Monitor state
  bit          done_seen;
  bit          done_error;
  int          mon_i, mon_j, mon_k;
  int          got_i [$];
  int          got_j [$];
  int          got_k [$];
  logic [15:0] got_data [$];

  tensor_product_top tensor_product_top_i (
    .CLK(CLK), .RST(RST), .start(start),
    .size_a_i(size_a_i), .size_a_j(size_a_j), .size_a_k(size_a_k),
    .size_b_i(size_b_i), .size_b_j(size_b_j), .size_b_k(size_b_k),
    .a_in_i_enable(a_in_i_enable), .a_in_j_enable(a_in_j_enable),
    .a_in_k_enable(a_in_k_enable), .data_a_in(data_a_in),
    .b_in_i_enable(b_in_i_enable), .b_in_j_enable(b_in_j_enable),
    .b_in_k_enable(b_in_k_enable), .data_b_in(data_b_in),
    .ready(ready), .error(error),
    .out_i_enable(out_i_enable), .out_j_enable(out_j_enable),
    .out_k_enable(out_k_enable), .data_out(data_out)
  );

  // 100 ns period
  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic int rand_bits(input int n);
    int value;
    int b;
    value = 0;
    for (b = 0; b < n; b++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return value;
  endfunction

  // Values at and next to the signed limits
  function automatic logic [15:0] limit_value();
    case (rand_bits(2))
      0:       return 16'h7FFF;
      1:       return 16'h8000;
      2:       return 16'hFFFF;
      default: return 16'h7FFE;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
      errors++;
      test_errors++;
    end
  endtask

  // Inputs change 5 ns after the rising edge
  task automatic next_cycle();
    @(posedge CLK);
    #5;
  endtask

  task automatic set_strobes(input bit is_b, input bit ie, input bit je, input bit ke,
                             input logic [15:0] value);
    if (is_b) begin
      b_in_i_enable = ie;
      b_in_j_enable = je;
      b_in_k_enable = ke;
      data_b_in     = value;
    end else begin
      a_in_i_enable = ie;
      a_in_j_enable = je;
      a_in_k_enable = ke;
      data_a_in     = value;
    end
  endtask

  // Row-major stream with random idle gaps
  task automatic stream_operand(input bit is_b, input int max_gap);
    int si, sj, sk, i, j, k, gap;
    logic [15:0] value;
    si = is_b ? sz_bi : sz_ai;
    sj = is_b ? sz_bj : sz_aj;
    sk = is_b ? sz_bk : sz_ak;
    for (i = 0; i < si; i++) begin
      for (j = 0; j < sj; j++) begin
        for (k = 0; k < sk; k++) begin
          value = is_b ? op_b[i*16 + j*4 + k] : op_a[i*16 + j*4 + k];
          set_strobes(is_b, (j == 0) && (k == 0), k == 0, 1'b1, value);
          next_cycle();
          set_strobes(is_b, 1'b0, 1'b0, 1'b0, 16'h0000);
          gap = (max_gap > 0) ? rand_bits(2) % (max_gap + 1) : 0;
          repeat (gap) next_cycle();
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Model and job setup
  //////////////////////////////////////////////////

  // out[i][j][k] = sum of A[i][j][m] * B[i][m][k], low 16 bits
  task automatic build_expected();
    int i, j, k, m;
    logic [15:0] sum;
    for (i = 0; i < sz_ai; i++) begin
      for (j = 0; j < sz_aj; j++) begin
        for (k = 0; k < sz_bk; k++) begin
          sum = 16'h0000;
          for (m = 0; m < sz_ak; m++) begin
            sum = sum + op_a[i*16 + j*4 + m] * op_b[i*16 + m*4 + k];
          end
          exp_out[i*16 + j*4 + k] = sum;
        end
      end
    end
  endtask

  task automatic pick_sizes(input bit valid);
    sz_ai = rand_bits(2) + 1;
    sz_aj = rand_bits(2) + 1;
    sz_ak = rand_bits(2) + 1;
    sz_bk = rand_bits(2) + 1;
    sz_bi = sz_ai;
    sz_bj = sz_ak;
    // Break either the I rule or the contraction rule
    if (!valid) begin
      if (rand_bits(1) == 1) sz_bi = (sz_ai % 4) + 1;
      else sz_bj = (sz_ak % 4) + 1;
    end
  endtask

  task automatic fill_operands(input bit near_limits);
    int n;
    for (n = 0; n < 64; n++) begin
      op_a[n] = near_limits ? limit_value() : 16'(rand_bits(16));
      op_b[n] = near_limits ? limit_value() : 16'(rand_bits(16));
    end
  endtask

  // One job from START to READY, then compare everything collected
  task automatic run_job(input string name, input bit b_first, input int max_gap);
    bit exp_error;
    int count, n, ei, ej, ek;
    exp_error = (sz_ai != sz_bi) || (sz_ak != sz_bj);
    test_errors = 0;
    got_i.delete();
    got_j.delete();
    got_k.delete();
    got_data.delete();
    mon_i = 0;
    mon_j = 0;
    mon_k = 0;
    done_seen = 1'b0;
    next_cycle();
    start    = 1'b1;
    size_a_i = 3'(sz_ai);
    size_a_j = 3'(sz_aj);
    size_a_k = 3'(sz_ak);
    size_b_i = 3'(sz_bi);
    size_b_j = 3'(sz_bj);
    size_b_k = 3'(sz_bk);
    next_cycle();
    start = 1'b0;
    if (!exp_error) begin
      stream_operand(b_first, max_gap);
      stream_operand(!b_first, max_gap);
    end
    // Watchdog bounds this wait
    wait (done_seen);
    check_value("error flag", done_error, exp_error);
    count = exp_error ? 0 : sz_ai * sz_aj * sz_bk;
    check_value("element count", got_data.size(), count);
    if (got_data.size() == count) begin
      for (n = 0; n < count; n++) begin
        ei = n / (sz_aj * sz_bk);
        ej = (n / sz_bk) % sz_aj;
        ek = n % sz_bk;
        check_value("output i", got_i[n], ei);
        check_value("output j", got_j[n], ej);
        check_value("output k", got_k[n], ek);
        check_value("output data", got_data[n], exp_out[ei*16 + ej*4 + ek]);
      end
    end
    $display("Test %0d %s: %s", test_num, name, (test_errors == 0) ? "ok" : "mismatch");
  endtask

  //////////////////////////////////////////////////
  // Monitor and watchdog
  //////////////////////////////////////////////////

  // Outputs settle by the falling edge
  always @(negedge CLK) begin
    if (!RST && out_k_enable) begin
      if (out_i_enable) begin
        mon_i = (got_data.size() == 0) ? 0 : mon_i + 1;
        mon_j = 0;
        mon_k = 0;
      end else if (out_j_enable) begin
        mon_j = mon_j + 1;
        mon_k = 0;
      end else begin
        mon_k = mon_k + 1;
      end
      got_i.push_back(mon_i);
      got_j.push_back(mon_j);
      got_k.push_back(mon_k);
      got_data.push_back(data_out);
    end
    if (!RST && ready) begin
      done_error = error;
      done_seen  = 1'b1;
    end
  end

  initial begin
    repeat (BUDGET) @(posedge CLK);
    $display("Timeout: the jobs did not finish within %0d clock cycles", BUDGET);
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    RST   = 1'b1;
    start = 1'b0;
    {size_a_i, size_a_j, size_a_k} = '0;
    {size_b_i, size_b_j, size_b_k} = '0;
    set_strobes(1'b0, 1'b0, 1'b0, 1'b0, 16'h0000);
    set_strobes(1'b1, 1'b0, 1'b0, 1'b0, 16'h0000);
    lfsr   = SEED;
    errors = 0;
    checks = 0;
    repeat (3) @(posedge CLK);
    #5;
    RST = 1'b0;

    // Every job starts in the cycle after the previous READY
    for (test_num = 0; test_num < NUM_TESTS; test_num++) begin
      if (test_num == 0) begin
        sz_ai = 2;
        sz_aj = 2;
        sz_ak = 2;
        sz_bi = 2;
        sz_bj = 2;
        sz_bk = 2;
        for (int n = 0; n < 8; n++) begin
          op_a[(n / 4) * 16 + ((n / 2) % 2) * 4 + n % 2] = 16'(n + 1);
          op_b[(n / 4) * 16 + ((n / 2) % 2) * 4 + n % 2] = 16'(n + 1);
          exp_out[(n / 4) * 16 + ((n / 2) % 2) * 4 + n % 2] = FIXED_OUT[n];
        end
        run_job("fixed 2x2x2", 1'b0, 0);
      end else if (test_num < 6) begin
        pick_sizes(1'b1);
        fill_operands(1'b0);
        build_expected();
        run_job("random sizes", 1'b0, 0);
      end else if (test_num < 8) begin
        pick_sizes(1'b0);
        run_job("size mismatch", 1'b0, 0);
      end else if (test_num < 10) begin
        pick_sizes(1'b1);
        fill_operands(1'b0);
        build_expected();
        run_job("B before A with gaps", 1'b1, 3);
      end else if (test_num < 12) begin
        pick_sizes(1'b1);
        fill_operands(1'b1);
        build_expected();
        run_job("signed limits", 1'(rand_bits(1)), 0);
      end else begin
        pick_sizes(1'b1);
        fill_operands(1'b0);
        build_expected();
        run_job("back to back", 1'(rand_bits(1)), 1);
      end
    end

    $display("Tests run: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/tensor_product_top.sv ====
//////////////////////////////////////////////////
// Contraction subsystem top level
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tensor_product_top
  import tensor_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  start,
  input  size_t size_a_i,
  input  size_t size_a_j,
  input  size_t size_a_k,
  input  size_t size_b_i,
  input  size_t size_b_j,
  input  size_t size_b_k,
  input  logic  a_in_i_enable,
  input  logic  a_in_j_enable,
  input  logic  a_in_k_enable,
  input  data_t data_a_in,
  input  logic  b_in_i_enable,
  input  logic  b_in_j_enable,
  input  logic  b_in_k_enable,
  input  data_t data_b_in,
  output logic  ready,
  output logic  error,
  output logic  out_i_enable,
  output logic  out_j_enable,
  output logic  out_k_enable,
  output data_t data_out
);

  // Buffer control and read side
  logic   clear;
  logic   a_full;
  logic   b_full;
  index_t a_i;
  index_t a_j;
  index_t a_k;
  index_t b_i;
  index_t b_j;
  index_t b_k;
  data_t  a_data;
  data_t  b_data;

  // Lengths held for the job
  size_t  a_size_i;
  size_t  a_size_j;
  size_t  a_size_k;
  size_t  b_size_i;
  size_t  b_size_j;
  size_t  b_size_k;

  // Multiplier handshake
  logic   mul_start;
  logic   mul_ready;
  data_t  mul_a;
  data_t  mul_b;
  data_t  mul_data;

  tensor_product controller (
    .CLK(CLK),
    .RST(RST),
    .start(start),
    .size_a_i(size_a_i),
    .size_a_j(size_a_j),
    .size_a_k(size_a_k),
    .size_b_i(size_b_i),
    .size_b_j(size_b_j),
    .size_b_k(size_b_k),
    .a_full(a_full),
    .b_full(b_full),
    .mul_ready(mul_ready),
    .a_data(a_data),
    .b_data(b_data),
    .mul_data(mul_data),
    .ready(ready),
    .error(error),
    .clear(clear),
    .mul_start(mul_start),
    .a_i(a_i),
    .a_j(a_j),
    .a_k(a_k),
    .b_i(b_i),
    .b_j(b_j),
    .b_k(b_k),
    .a_size_i(a_size_i),
    .a_size_j(a_size_j),
    .a_size_k(a_size_k),
    .b_size_i(b_size_i),
    .b_size_j(b_size_j),
    .b_size_k(b_size_k),
    .mul_a(mul_a),
    .mul_b(mul_b),
    .out_i_enable(out_i_enable),
    .out_j_enable(out_j_enable),
    .out_k_enable(out_k_enable),
    .data_out(data_out)
  );

  // A operand, I x J x K
  tensor_buffer a_buffer (
    .CLK(CLK),
    .RST(RST),
    .clear(clear),
    .size_i(a_size_i),
    .size_j(a_size_j),
    .size_k(a_size_k),
    .in_i_enable(a_in_i_enable),
    .in_j_enable(a_in_j_enable),
    .in_k_enable(a_in_k_enable),
    .data_in(data_a_in),
    .rd_i(a_i),
    .rd_j(a_j),
    .rd_k(a_k),
    .data_rd(a_data),
    .full(a_full)
  );

  // B operand, I x M x K
  tensor_buffer b_buffer (
    .CLK(CLK),
    .RST(RST),
    .clear(clear),
    .size_i(b_size_i),
    .size_j(b_size_j),
    .size_k(b_size_k),
    .in_i_enable(b_in_i_enable),
    .in_j_enable(b_in_j_enable),
    .in_k_enable(b_in_k_enable),
    .data_in(data_b_in),
    .rd_i(b_i),
    .rd_j(b_j),
    .rd_k(b_k),
    .data_rd(b_data),
    .full(b_full)
  );

  scalar_multiplier multiplier (
    .CLK(CLK),
    .RST(RST),
    .start(mul_start),
    .data_a(mul_a),
    .data_b(mul_b),
    .ready(mul_ready),
    .data_out(mul_data)
  );

endmodule

// ==== hdl/tensor_product.sv ====
//////////////////////////////////////////////////
// Contraction controller with size check
// and wrapping accumulator
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tensor_product
  import tensor_pkg::*;
  import tensor_ctrl_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,
  input  logic   start,
  input  size_t  size_a_i,
  input  size_t  size_a_j,
  input  size_t  size_a_k,
  input  size_t  size_b_i,
  input  size_t  size_b_j,
  input  size_t  size_b_k,
  input  logic   a_full,
  input  logic   b_full,
  input  logic   mul_ready,
  input  data_t  a_data,
  input  data_t  b_data,
  input  data_t  mul_data,
  output logic   ready,
  output logic   error,
  output logic   clear,
  output logic   mul_start,
  output index_t a_i,
  output index_t a_j,
  output index_t a_k,
  output index_t b_i,
  output index_t b_j,
  output index_t b_k,
  output size_t  a_size_i,
  output size_t  a_size_j,
  output size_t  a_size_k,
  output size_t  b_size_i,
  output size_t  b_size_j,
  output size_t  b_size_k,
  output data_t  mul_a,
  output data_t  mul_b,
  output logic   out_i_enable,
  output logic   out_j_enable,
  output logic   out_k_enable,
  output data_t  data_out
);

  product_state_t state;

  // Output coordinates and inner index
  index_t i;
  index_t j;
  index_t k;
  index_t m;

  // Loop bounds from the latched lengths
  index_t last_i;
  index_t last_j;
  index_t last_k;
  index_t last_m;

  // Running sum for one output element
  data_t  acc;

  assign last_i = index_t'(a_size_i - 1'b1);
  assign last_j = index_t'(a_size_j - 1'b1);
  assign last_k = index_t'(b_size_k - 1'b1);
  assign last_m = index_t'(a_size_k - 1'b1);

  // A[i][j][m] and B[i][m][k]
  assign a_i = i;
  assign a_j = j;
  assign a_k = m;
  assign b_i = i;
  assign b_j = m;
  assign b_k = k;

  // Operands stay put while the multiplier runs
  assign mul_a = a_data;
  assign mul_b = b_data;

  //////////////////////////////////////////////////
  // Job FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= IDLE;
      ready        <= 1'b0;
      error        <= 1'b0;
      clear        <= 1'b0;
      mul_start    <= 1'b0;
      out_i_enable <= 1'b0;
      out_j_enable <= 1'b0;
      out_k_enable <= 1'b0;
      data_out     <= '0;
      acc          <= '0;
      i            <= '0;
      j            <= '0;
      k            <= '0;
      m            <= '0;
      a_size_i     <= '0;
      a_size_j     <= '0;
      a_size_k     <= '0;
      b_size_i     <= '0;
      b_size_j     <= '0;
      b_size_k     <= '0;
    end else begin
      // Pulses last one cycle
      ready        <= 1'b0;
      error        <= 1'b0;
      clear        <= 1'b0;
      mul_start    <= 1'b0;
      out_i_enable <= 1'b0;
      out_j_enable <= 1'b0;
      out_k_enable <= 1'b0;

      case (state)
        // DONE also takes a start so jobs can run back to back
        IDLE, DONE: begin
          state <= IDLE;
          if (start) begin
            a_size_i <= size_a_i;
            a_size_j <= size_a_j;
            a_size_k <= size_a_k;
            b_size_i <= size_b_i;
            b_size_j <= size_b_j;
            b_size_k <= size_b_k;
            if (size_a_i != size_b_i || size_a_k != size_b_j) begin
              // Mismatch ends the job with no output
              ready <= 1'b1;
              error <= 1'b1;
              state <= DONE;
            end else begin
              clear <= 1'b1;
              state <= LOAD;
            end
          end
        end

        // Full flags are stale while clear is still high
        LOAD: begin
          if (!clear && a_full && b_full) begin
            i     <= '0;
            j     <= '0;
            k     <= '0;
            m     <= '0;
            acc   <= '0;
            state <= MULTIPLY;
          end
        end

        MULTIPLY: begin
          mul_start <= 1'b1;
          state     <= ACCUMULATE;
        end

        // Sum wraps modulo 2^16
        ACCUMULATE: begin
          if (mul_ready) begin
            acc <= acc + mul_data;
            if (m == last_m) begin
              state <= EMIT;
            end else begin
              m     <= m + 1'b1;
              state <= MULTIPLY;
            end
          end
        end

        // Row strobe on k == 0, slice strobe on j == k == 0
        EMIT: begin
          data_out     <= acc;
          out_k_enable <= 1'b1;
          out_j_enable <= (k == '0);
          out_i_enable <= (j == '0) && (k == '0);
          state        <= ADVANCE;
        end

        ADVANCE: begin
          acc   <= '0;
          m     <= '0;
          state <= MULTIPLY;
          if (k != last_k) begin
            k <= k + 1'b1;
          end else begin
            k <= '0;
            if (j != last_j) begin
              j <= j + 1'b1;
            end else begin
              j <= '0;
              if (i != last_i) begin
                i <= i + 1'b1;
              end else begin
                // Ready right after the final element
                ready <= 1'b1;
                state <= DONE;
              end
            end
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Boundary strobes ride on an element strobe
  assert property (@(posedge CLK) disable iff (RST)
    (out_i_enable || out_j_enable) |-> out_k_enable);

endmodule

// ==== hdl/tensor_buffer.sv ====
//////////////////////////////////////////////////
// Operand store filled by enable strobes
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "tensor_defs.svh"

module tensor_buffer
  import tensor_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,
  input  logic   clear,
  input  size_t  size_i,
  input  size_t  size_j,
  input  size_t  size_k,
  input  logic   in_i_enable,
  input  logic   in_j_enable,
  input  logic   in_k_enable,
  input  data_t  data_in,
  input  index_t rd_i,
  input  index_t rd_j,
  input  index_t rd_k,
  output data_t  data_rd,
  output logic   full
);

  data_t  mem [`TENSOR_DEPTH];

  // Coordinates of the last element written
  index_t cnt_i;
  index_t cnt_j;
  index_t cnt_k;

  // Coordinates of the element on the bus now
  index_t wr_i;
  index_t wr_j;
  index_t wr_k;

  logic   started;
  logic   first;
  logic   we;
  logic   last;

  //////////////////////////////////////////////////
  // Write position from the strobes
  //////////////////////////////////////////////////

  // A write in the clear cycle counts as the first element
  assign first = clear || !started;

  // Slice strobe bumps i, row strobe bumps j, else k steps
  always_comb begin
    wr_i = cnt_i;
    wr_j = cnt_j;
    wr_k = cnt_k + 1'b1;
    if (in_i_enable) begin
      wr_i = first ? '0 : cnt_i + 1'b1;
      wr_j = '0;
      wr_k = '0;
    end else if (in_j_enable) begin
      wr_j = cnt_j + 1'b1;
      wr_k = '0;
    end
  end

  // Strobes after the tensor is complete are dropped
  assign we   = in_k_enable && (clear || !full);
  assign last = (wr_i == index_t'(size_i - 1'b1)) &&
                (wr_j == index_t'(size_j - 1'b1)) &&
                (wr_k == index_t'(size_k - 1'b1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      full    <= 1'b0;
      started <= 1'b0;
      cnt_i   <= '0;
      cnt_j   <= '0;
      cnt_k   <= '0;
    end else if (we) begin
      full    <= last;
      started <= 1'b1;
      cnt_i   <= wr_i;
      cnt_j   <= wr_j;
      cnt_k   <= wr_k;
    end else if (clear) begin
      full    <= 1'b0;
      started <= 1'b0;
      cnt_i   <= '0;
      cnt_j   <= '0;
      cnt_k   <= '0;
    end
  end

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[tensor_addr(wr_i, wr_j, wr_k)] <= data_in;
    end
  end

  // Combinational read for the controller
  assign data_rd = mem[tensor_addr(rd_i, rd_j, rd_k)];

  // Host streams exactly one tensor per job
  assert property (@(posedge CLK) disable iff (RST) in_k_enable && !clear |-> !full);

  // Controller only arms the store with lengths that fit the cube
  assert property (@(posedge CLK) disable iff (RST)
    clear |-> size_i != '0 && size_i <= size_t'(`TENSOR_MAX_DIM) &&
              size_j != '0 && size_j <= size_t'(`TENSOR_MAX_DIM) &&
              size_k != '0 && size_k <= size_t'(`TENSOR_MAX_DIM));

endmodule

// ==== hdl/scalar_multiplier.sv ====
//////////////////////////////////////////////////
// Sequential shift-add multiplier, 16 steps
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "tensor_defs.svh"

module scalar_multiplier
  import tensor_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  start,
  input  data_t data_a,
  input  data_t data_b,
  output logic  ready,
  output data_t data_out
);

  // One step per multiplier bit
  localparam int CNT_W = $clog2(`TENSOR_DATA_WIDTH);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`TENSOR_DATA_WIDTH - 1);

  logic             busy;
  logic [CNT_W-1:0] count;
  data_t            mcand;
  data_t            mplier;
  data_t            product;

  //////////////////////////////////////////////////
  // Step sequencing
  //////////////////////////////////////////////////

  // Ready lands 17 cycles after start
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      ready <= 1'b0;
      count <= '0;
    end else begin
      ready <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (busy) begin
        count <= count + 1'b1;
        if (count == LAST_STEP) begin
          busy  <= 1'b0;
          ready <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Shift-add datapath
  //////////////////////////////////////////////////

  // Low 16 bits only, same as the wrapped signed product
  always_ff @(posedge CLK) begin
    if (start) begin
      mcand   <= data_a;
      mplier  <= data_b;
      product <= '0;
    end else if (busy) begin
      if (mplier[0]) begin
        product <= product + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Held until the next start
  assign data_out = product;

  // A new operand pair only once the previous product is out
  assert property (@(posedge CLK) disable iff (RST) start |-> !busy);

endmodule

// ==== hdl/tensor_ctrl_pkg.sv ====
//////////////////////////////////////////////////
// Contraction controller state encoding
//////////////////////////////////////////////////

package tensor_ctrl_pkg;

  // Job flow of the controller
  typedef enum logic [2:0] {
    IDLE,       // Waiting for start
    LOAD,       // Operands streaming in
    MULTIPLY,   // Issue one product
    ACCUMULATE, // Wait for product, add it
    EMIT,       // Drive one output element
    ADVANCE,    // Step k, j, i
    DONE        // Ready pulse visible
  } product_state_t;

endpackage

// ==== hdl/tensor_pkg.sv ====
//////////////////////////////////////////////////
// Datapath vector types and buffer address packing
//////////////////////////////////////////////////

`include "tensor_defs.svh"

package tensor_pkg;

  // One element, wraps modulo 2^16
  typedef logic [`TENSOR_DATA_WIDTH-1:0] data_t;

  // One coordinate, 0 to 3
  typedef logic [`TENSOR_INDEX_WIDTH-1:0] index_t;

  // One dimension length, 1 to 4
  typedef logic [`TENSOR_SIZE_WIDTH-1:0] size_t;

  // Store address, i in the top field and k in the bottom
  typedef logic [$clog2(`TENSOR_DEPTH)-1:0] addr_t;

  function automatic addr_t tensor_addr(index_t i, index_t j, index_t k);
    return {i, j, k};
  endfunction

endpackage

// ==== hdl/tensor_defs.svh ====
//////////////////////////////////////////////////
// Widths and capacity of the tensor datapath
//////////////////////////////////////////////////

`ifndef TENSOR_DEFS_SVH
`define TENSOR_DEFS_SVH

// Element width, two's complement
`define TENSOR_DATA_WIDTH 16

// Largest length of any dimension
`define TENSOR_MAX_DIM 4

// Bits of one coordinate and of one length
`define TENSOR_INDEX_WIDTH 2
`define TENSOR_SIZE_WIDTH 3

// Elements per operand store, one full cube
`define TENSOR_DEPTH 64

`endif
